// ==== video_pkg.sv ====
package video_pkg;

    // Pixel position on the 640x480 raster
    typedef logic [9:0] coord_t;

    // Tile index along one grid axis
    typedef logic [4:0] tile_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    localparam int TILE_SIZE = 26;

    localparam rgb_t COL_BLACK      = 12'h000;
    localparam rgb_t COL_WHITE      = 12'hFFF;
    localparam rgb_t COL_BANNER_RED = 12'hF00;
    localparam rgb_t COL_BG         = 12'h111;
    localparam rgb_t COL_GRID       = 12'h222;
    localparam rgb_t COL_PATH       = 12'h532;
    localparam rgb_t COL_ENEMY      = 12'hD22;
    localparam rgb_t COL_CURSOR     = 12'hFF0;
    localparam rgb_t COL_UI         = 12'h222;

endpackage

// ==== game_pkg.sv ====
package game_pkg;

    typedef enum logic [1:0] {
        ST_MENU,
        ST_GAME,
        ST_GAMEOVER
    } game_state_e;

    typedef enum logic [1:0] {
        SW_IDLE,
        SW_ENEMIES,
        SW_SPAWN
    } sweep_e;

    localparam int GRID_W         = 24;
    localparam int GRID_H         = 18;
    localparam int CURSOR_HOME_X  = 12;
    localparam int CURSOR_HOME_Y  = 9;
    localparam int MAX_LIVES      = 10;
    localparam int PATH_END       = 2200;
    localparam int SPAWN_INTERVAL = 31;

    // Progress at each path corner
    localparam int PATH_C1 = 507;
    localparam int PATH_C2 = 741;
    localparam int PATH_C3 = 1115;
    localparam int PATH_C4 = 1245;
    localparam int PATH_C5 = 1499;
    localparam int PATH_C6 = 1729;

    // Fixed coordinate of each of the seven segments
    localparam int PATH_Y0 = 73;
    localparam int PATH_X1 = 507;
    localparam int PATH_Y2 = 307;
    localparam int PATH_X3 = 133;
    localparam int PATH_Y4 = 177;
    localparam int PATH_X5 = 387;
    localparam int PATH_Y6 = 407;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic center;
    } press_t;

    typedef struct packed {
        logic [4:0] x;
        logic [4:0] y;
    } cursor_t;

    typedef struct packed {
        logic        active;
        logic [15:0] progress;
        logic [9:0]  x;
        logic [9:0]  y;
    } enemy_t;

endpackage

// ==== player_input.sv ====
module player_input import video_pkg::*, game_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  coord_t      x_i,
    input  coord_t      y_i,
    input  logic        btn_up_i,
    input  logic        btn_down_i,
    input  logic        btn_left_i,
    input  logic        btn_right_i,
    input  logic        btn_center_i,
    input  game_state_e state_i,
    input  logic        new_game_i,
    output press_t      press_o,
    output cursor_t     cursor_o
);
    logic    frame_strobe;
    press_t  btn_now;
    press_t  btn_prev_q;
    cursor_t cursor_q;

    // First pixel of the frame
    assign frame_strobe = (x_i == '0) && (y_i == '0);

    assign btn_now = '{
        up:     btn_up_i,
        down:   btn_down_i,
        left:   btn_left_i,
        right:  btn_right_i,
        center: btn_center_i
    };

    assign press_o = frame_strobe ? press_t'(btn_now & ~btn_prev_q) : '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            btn_prev_q <= '0;
        end else if (frame_strobe) begin
            btn_prev_q <= btn_now;
        end
    end

    // One tile per press, held inside the grid
    always_ff @(posedge clk) begin
        if (reset_i || new_game_i) begin
            cursor_q.x <= 5'(CURSOR_HOME_X);
            cursor_q.y <= 5'(CURSOR_HOME_Y);
        end else if (state_i == ST_GAME) begin
            if (press_o.up && cursor_q.y != '0) begin
                cursor_q.y <= cursor_q.y - 1'b1;
            end else if (press_o.down && cursor_q.y != 5'(GRID_H - 1)) begin
                cursor_q.y <= cursor_q.y + 1'b1;
            end
            if (press_o.left && cursor_q.x != '0) begin
                cursor_q.x <= cursor_q.x - 1'b1;
            end else if (press_o.right && cursor_q.x != 5'(GRID_W - 1)) begin
                cursor_q.x <= cursor_q.x + 1'b1;
            end
        end
    end

    assign cursor_o = cursor_q;

endmodule

// ==== game_flow.sv ====
module game_flow import game_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        center_i,
    input  logic        escape_i,
    output game_state_e state_o,
    output logic [3:0]  lives_o,
    output logic        new_game_o
);
    game_state_e state_q;
    logic [3:0]  lives_q;

    // Starts a new game on the same edge as the state change
    assign new_game_o = (state_q == ST_MENU) && center_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_MENU;
            lives_q <= 4'(MAX_LIVES);
        end else begin
            case (state_q)
                ST_MENU: begin
                    if (center_i) begin
                        state_q <= ST_GAME;
                        lives_q <= 4'(MAX_LIVES);
                    end
                end
                ST_GAME: begin
                    if (escape_i && lives_q != '0) begin
                        lives_q <= lives_q - 1'b1;
                        if (lives_q == 4'd1) begin
                            state_q <= ST_GAMEOVER;
                        end
                    end
                end
                ST_GAMEOVER: begin
                    if (center_i) begin
                        state_q <= ST_MENU;
                    end
                end
                default: state_q <= ST_MENU;
            endcase
        end
    end

    assign state_o = state_q;
    assign lives_o = lives_q;

endmodule

// ==== wave_engine.sv ====
module wave_engine import game_pkg::*; #(
    parameter int MAX_ENEMIES = 16,
    parameter int TICK_DIV    = 8333
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  game_state_e              state_i,
    input  logic                     new_game_i,
    output enemy_t [MAX_ENEMIES-1:0] enemies_o,
    output logic                     escape_o
);
    localparam int IDX_W = (MAX_ENEMIES > 1) ? $clog2(MAX_ENEMIES) : 1;
    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam int SPN_W = $clog2(SPAWN_INTERVAL);

    enemy_t [MAX_ENEMIES-1:0] slots_q;
    logic [DIV_W-1:0]         div_q;
    logic                     tick;
    sweep_e                   sweep_q;
    logic [IDX_W-1:0]         idx_q;
    logic [SPN_W-1:0]         spawn_cnt_q;
    logic                     free_found;
    logic [IDX_W-1:0]         free_idx;
    enemy_t                   cur;
    logic [15:0]              next_prog;

    // Position along the seven segments, returned as {x, y}
    function automatic logic [19:0] path_xy(input logic [15:0] p);
        int pi;
        int ex;
        int ey;
        pi = int'(p);
        if (pi < PATH_C1) begin
            ex = pi;
            ey = PATH_Y0;
        end else if (pi < PATH_C2) begin
            ex = PATH_X1;
            ey = PATH_Y0 + (pi - PATH_C1);
        end else if (pi < PATH_C3) begin
            ex = PATH_X1 - (pi - PATH_C2);
            ey = PATH_Y2;
        end else if (pi < PATH_C4) begin
            ex = PATH_X3;
            ey = PATH_Y2 - (pi - PATH_C3);
        end else if (pi < PATH_C5) begin
            ex = PATH_X3 + (pi - PATH_C4);
            ey = PATH_Y4;
        end else if (pi < PATH_C6) begin
            ex = PATH_X5;
            ey = PATH_Y4 + (pi - PATH_C5);
        end else begin
            ex = PATH_X5 - (pi - PATH_C6);
            ey = PATH_Y6;
        end
        return {10'(ex), 10'(ey)};
    endfunction

    assign tick = (div_q == '0);

    always_ff @(posedge clk) begin
        if (reset_i || new_game_i || tick) begin
            div_q <= DIV_W'(TICK_DIV - 1);
        end else begin
            div_q <= div_q - 1'b1;
        end
    end

    // Lowest inactive slot
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = MAX_ENEMIES - 1; i >= 0; i--) begin
            if (!slots_q[i].active) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    assign cur       = slots_q[idx_q];
    assign next_prog = cur.progress + 16'd1;

    always_ff @(posedge clk) begin
        escape_o <= 1'b0;
        if (reset_i || new_game_i) begin
            sweep_q     <= SW_IDLE;
            idx_q       <= '0;
            spawn_cnt_q <= '0;
            for (int i = 0; i < MAX_ENEMIES; i++) begin
                slots_q[i].active <= 1'b0;
            end
        end else if (state_i == ST_GAME && tick) begin
            case (sweep_q)
                SW_IDLE: begin
                    sweep_q <= SW_ENEMIES;
                    idx_q   <= '0;
                end
                SW_ENEMIES: begin
                    if (cur.active) begin
                        if (cur.progress > 16'(PATH_END)) begin
                            slots_q[idx_q].active <= 1'b0;
                            escape_o              <= 1'b1;
                        end else begin
                            slots_q[idx_q].progress <= next_prog;
                            {slots_q[idx_q].x, slots_q[idx_q].y} <= path_xy(next_prog);
                        end
                    end
                    if (idx_q == IDX_W'(MAX_ENEMIES - 1)) begin
                        sweep_q <= SW_SPAWN;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                SW_SPAWN: begin
                    sweep_q <= SW_ENEMIES;
                    idx_q   <= '0;
                    if (spawn_cnt_q == SPN_W'(SPAWN_INTERVAL - 1)) begin
                        spawn_cnt_q <= '0;
                        if (free_found) begin
                            slots_q[free_idx].active   <= 1'b1;
                            slots_q[free_idx].progress <= '0;
                            {slots_q[free_idx].x, slots_q[free_idx].y} <= path_xy(16'd0);
                        end
                    end else begin
                        spawn_cnt_q <= spawn_cnt_q + 1'b1;
                    end
                end
                default: sweep_q <= SW_IDLE;
            endcase
        end
    end

    assign enemies_o = slots_q;

endmodule

// ==== scene_render.sv ====
module scene_render import video_pkg::*, game_pkg::*; #(
    parameter int MAX_ENEMIES = 16
) (
    input  coord_t                   x_i,
    input  coord_t                   y_i,
    input  logic                     visible_i,
    input  game_state_e              state_i,
    input  cursor_t                  cursor_i,
    input  enemy_t [MAX_ENEMIES-1:0] enemies_i,
    output rgb_t                     pixel_o
);
    localparam int PATH_HALF  = TILE_SIZE / 2;
    localparam int ENEMY_HALF = 7;
    localparam int UI_BAR_H   = 25;

    tile_t      grid_x;
    tile_t      grid_y;
    logic [4:0] off_x;
    logic [4:0] off_y;
    logic       on_path;
    logic       on_enemy;
    logic       on_cursor;
    logic       in_menu_banner;
    logic       in_over_banner;

    function automatic logic in_range(input int v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    // Band of half a tile on each side of every segment
    function automatic logic path_hit(input int px, input int py);
        return (in_range(py, PATH_Y0 - PATH_HALF, PATH_Y0 + PATH_HALF) &&
                in_range(px, 0, PATH_X1 + PATH_HALF)) ||
               (in_range(px, PATH_X1 - PATH_HALF, PATH_X1 + PATH_HALF) &&
                in_range(py, PATH_Y0 - PATH_HALF, PATH_Y2 + PATH_HALF)) ||
               (in_range(py, PATH_Y2 - PATH_HALF, PATH_Y2 + PATH_HALF) &&
                in_range(px, PATH_X3 - PATH_HALF, PATH_X1 + PATH_HALF)) ||
               (in_range(px, PATH_X3 - PATH_HALF, PATH_X3 + PATH_HALF) &&
                in_range(py, PATH_Y4 - PATH_HALF, PATH_Y2 + PATH_HALF)) ||
               (in_range(py, PATH_Y4 - PATH_HALF, PATH_Y4 + PATH_HALF) &&
                in_range(px, PATH_X3 - PATH_HALF, PATH_X5 + PATH_HALF)) ||
               (in_range(px, PATH_X5 - PATH_HALF, PATH_X5 + PATH_HALF) &&
                in_range(py, PATH_Y4 - PATH_HALF, PATH_Y6 + PATH_HALF)) ||
               (in_range(py, PATH_Y6 - PATH_HALF, PATH_Y6 + PATH_HALF) &&
                in_range(px, 0, PATH_X5 + PATH_HALF));
    endfunction

    assign grid_x = tile_t'(x_i / TILE_SIZE);
    assign grid_y = tile_t'(y_i / TILE_SIZE);
    assign off_x  = 5'(x_i % TILE_SIZE);
    assign off_y  = 5'(y_i % TILE_SIZE);

    assign on_path = path_hit(int'(x_i), int'(y_i));

    always_comb begin
        on_enemy = 1'b0;
        for (int i = 0; i < MAX_ENEMIES; i++) begin
            if (enemies_i[i].active &&
                in_range(int'(x_i), int'(enemies_i[i].x) - ENEMY_HALF,
                         int'(enemies_i[i].x) + ENEMY_HALF) &&
                in_range(int'(y_i), int'(enemies_i[i].y) - ENEMY_HALF,
                         int'(enemies_i[i].y) + ENEMY_HALF)) begin
                on_enemy = 1'b1;
            end
        end
    end

    // Crosshair in the middle of the cursor tile
    assign on_cursor = (grid_x == cursor_i.x) && (grid_y == cursor_i.y) &&
                       ((((off_y == 5'd12) || (off_y == 5'd13)) &&
                         in_range(int'(off_x), 7, 18)) ||
                        (((off_x == 5'd12) || (off_x == 5'd13)) &&
                         in_range(int'(off_y), 7, 18)));

    assign in_menu_banner = in_range(int'(x_i), 160, 479) && in_range(int'(y_i), 100, 139);
    assign in_over_banner = in_range(int'(x_i), 200, 439) && in_range(int'(y_i), 180, 219);

    always_comb begin
        pixel_o = COL_BLACK;
        if (visible_i) begin
            case (state_i)
                ST_MENU: begin
                    if (in_menu_banner) begin
                        pixel_o = COL_WHITE;
                    end
                end
                ST_GAME: begin
                    // Later layers win
                    pixel_o = COL_BG;
                    if (off_x == '0 || off_y == '0) begin
                        pixel_o = COL_GRID;
                    end
                    if (on_path) begin
                        pixel_o = COL_PATH;
                    end
                    if (on_enemy) begin
                        pixel_o = COL_ENEMY;
                    end
                    if (on_cursor) begin
                        pixel_o = COL_CURSOR;
                    end
                    if (int'(y_i) < UI_BAR_H) begin
                        pixel_o = COL_UI;
                    end
                end
                ST_GAMEOVER: begin
                    if (in_over_banner) begin
                        pixel_o = COL_BANNER_RED;
                    end
                end
                default: pixel_o = COL_BLACK;
            endcase
        end
    end

endmodule

// ==== tower_defense_top.sv ====
module tower_defense_top import video_pkg::*, game_pkg::*; #(
    parameter int MAX_ENEMIES = 16,
    parameter int TICK_DIV    = 8333
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       visible_i,
    input  coord_t     x_i,
    input  coord_t     y_i,
    input  logic       btn_up_i,
    input  logic       btn_down_i,
    input  logic       btn_left_i,
    input  logic       btn_right_i,
    input  logic       btn_center_i,
    output rgb_t       pixel_o,
    output logic [3:0] lives_o
);
    press_t                   press;
    cursor_t                  cursor;
    game_state_e              state;
    logic                     new_game;
    logic                     escape;
    enemy_t [MAX_ENEMIES-1:0] enemies;

    player_input player_input_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .x_i          (x_i),
        .y_i          (y_i),
        .btn_up_i     (btn_up_i),
        .btn_down_i   (btn_down_i),
        .btn_left_i   (btn_left_i),
        .btn_right_i  (btn_right_i),
        .btn_center_i (btn_center_i),
        .state_i      (state),
        .new_game_i   (new_game),
        .press_o      (press),
        .cursor_o     (cursor)
    );

    game_flow game_flow_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .center_i   (press.center),
        .escape_i   (escape),
        .state_o    (state),
        .lives_o    (lives_o),
        .new_game_o (new_game)
    );

    wave_engine #(
        .MAX_ENEMIES (MAX_ENEMIES),
        .TICK_DIV    (TICK_DIV)
    ) wave_engine_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .state_i    (state),
        .new_game_i (new_game),
        .enemies_o  (enemies),
        .escape_o   (escape)
    );

    scene_render #(
        .MAX_ENEMIES (MAX_ENEMIES)
    ) scene_render_inst (
        .x_i       (x_i),
        .y_i       (y_i),
        .visible_i (visible_i),
        .state_i   (state),
        .cursor_i  (cursor),
        .enemies_i (enemies),
        .pixel_o   (pixel_o)
    );

endmodule

// ==== tb_tower_defense.sv ====
module tb_tower_defense import video_pkg::*, game_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TB_MAX_ENEMIES    = 4;
    localparam int TB_TICK_DIV       = 1;
    localparam int STIM_DEPTH        = 64;
    localparam int CYCLES_PER_RECORD = 64;

    localparam logic [3:0] OP_END   = 4'h0;
    localparam logic [3:0] OP_PRESS = 4'h1;
    localparam logic [3:0] OP_PROBE = 4'h2;
    localparam logic [3:0] OP_WAIT  = 4'h3;

    // One line of the stimulus file
    typedef struct packed {
        logic [3:0]  op;
        logic [3:0]  vis;
        logic [11:0] x;
        logic [11:0] y;
        logic [11:0] value;
    } stim_rec_t;

    logic        clk;
    logic        reset_i;
    logic        visible_i;
    coord_t      x_i;
    coord_t      y_i;
    logic        btn_up_i;
    logic        btn_down_i;
    logic        btn_left_i;
    logic        btn_right_i;
    logic        btn_center_i;
    rgb_t        pixel_o;
    logic [3:0]  lives_o;

    logic [43:0] stim_mem [0:STIM_DEPTH-1];
    int          record_count;
    int          cycle_limit;
    int          cycle_count;
    int          mismatch_count;
    int          failure_count;

    tower_defense_top #(
        .MAX_ENEMIES (TB_MAX_ENEMIES),
        .TICK_DIV    (TB_TICK_DIV)
    ) tower_defense_top_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .visible_i    (visible_i),
        .x_i          (x_i),
        .y_i          (y_i),
        .btn_up_i     (btn_up_i),
        .btn_down_i   (btn_down_i),
        .btn_left_i   (btn_left_i),
        .btn_right_i  (btn_right_i),
        .btn_center_i (btn_center_i),
        .pixel_o      (pixel_o),
        .lives_o      (lives_o)
    );

    always #2 clk = ~clk;

    task automatic finish_run();
        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // One frame start with the given button levels, then an idle cycle
    task automatic drive_strobe(input logic [4:0] mask);
        @(negedge clk);
        x_i = '0;
        y_i = '0;
        {btn_up_i, btn_down_i, btn_left_i, btn_right_i, btn_center_i} = mask;
        @(negedge clk);
        x_i = 10'd1;
        y_i = 10'd1;
    endtask

    // Release frame after each press so the next one is a new edge
    task automatic press_buttons(input int count, input logic [4:0] mask);
        for (int n = 0; n < count; n++) begin
            drive_strobe(mask);
            drive_strobe(5'b0);
        end
    endtask

    task automatic probe_pixel(input logic vis, input coord_t px, input coord_t py,
                               input rgb_t expected);
        @(negedge clk);
        visible_i = vis;
        x_i       = px;
        y_i       = py;
        @(negedge clk);
        assert (pixel_o == expected) else begin
            $display("MISMATCH at %0t: pixel (%0d,%0d) visible %0b is %h, expected %h",
                     $time, px, py, vis, pixel_o, expected);
            mismatch_count++;
        end
        visible_i = 1'b0;
        x_i       = 10'd1;
        y_i       = 10'd1;
    endtask

    // Lives may only sit at the target or one above it
    task automatic wait_lives(input logic [3:0] target);
        logic [3:0] start_lives;
        logic       stray;
        @(negedge clk);
        start_lives = lives_o;
        stray = (int'(start_lives) - int'(target) != 0) &&
                (int'(start_lives) - int'(target) != 1);
        while (lives_o != target && !stray) begin
            @(negedge clk);
            stray = (lives_o != target) && (lives_o != start_lives);
        end
        assert (!stray) else begin
            $display("MISMATCH at %0t: lives went from %0d to %0d while waiting for %0d",
                     $time, start_lives, lives_o, target);
            mismatch_count++;
        end
    endtask

    initial begin
        stim_rec_t rec;
        clk            = 1'b0;
        reset_i        = 1'b1;
        visible_i      = 1'b0;
        x_i            = 10'd1;
        y_i            = 10'd1;
        btn_up_i       = 1'b0;
        btn_down_i     = 1'b0;
        btn_left_i     = 1'b0;
        btn_right_i    = 1'b0;
        btn_center_i   = 1'b0;
        mismatch_count = 0;
        failure_count  = 0;
        record_count   = 0;

        for (int i = 0; i < STIM_DEPTH; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("tower_defense_stim.txt", stim_mem);
        while (record_count < STIM_DEPTH && stim_mem[record_count][43:40] != OP_END) begin
            record_count++;
        end
        if (record_count == 0) begin
            $display("The stimulus file is missing or holds no records");
            failure_count++;
        end

        // Every escape takes a full path of sweeps in the worst case
        cycle_limit = record_count * CYCLES_PER_RECORD +
                      MAX_LIVES * (PATH_END + 2) * (TB_MAX_ENEMIES + 1);

        repeat (4) @(negedge clk);
        reset_i = 1'b0;

        for (int i = 0; i < record_count; i++) begin
            rec = stim_rec_t'(stim_mem[i]);
            case (rec.op)
                OP_PRESS: press_buttons(int'(rec.x), rec.value[4:0]);
                OP_PROBE: probe_pixel(rec.vis[0], rec.x[9:0], rec.y[9:0], rgb_t'(rec.value));
                OP_WAIT:  wait_lives(rec.value[3:0]);
                default: begin
                    $display("Stimulus record %0d has an unknown operation %h", i, rec.op);
                    failure_count++;
                end
            endcase
        end
        finish_run();
    end

    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d clock cycles with stimulus still running", cycle_count);
        failure_count++;
        finish_run();
    end

endmodule

// ==== tower_defense_stim.txt ====
// Each record is op, visible, x, y and value with 1, 1, 3, 3 and 3 hex digits
// Op 1 presses mask (up down left right center) x times, op 2 probes, op 3 waits for lives
// Menu after reset
2112C078FFF
21064032000
2012C078000
// Start the game
10001000001
212581C2111
212561C2222
210FA049532
2112C00A222
202581C2000
3000000000A
// Cursor moves
211440F4FF0
10001000002
10002000010
2115C0C3FF0
211440F4111
1001E000004
2100C0C3FF0
210260C3111
// Escapes
30000000009
30000000008
30000000007
30000000006
30000000005
30000000004
30000000003
30000000002
30000000001
30000000000
// Game over and back to the menu
211400C8F00
21064064000
10001000001
2112C078FFF
// Second game
10001000001
3000000000A
211440F4FF0

// ==== flist.f ====
video_pkg.sv
game_pkg.sv
player_input.sv
game_flow.sv
wave_engine.sv
scene_render.sv
tower_defense_top.sv
tb_tower_defense.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_tower_defense
FLIST     = flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
